// ==== ufiPkg.sv ====
// UFI bus shared definitions
`default_nettype none

package ufiPkg;

	// ----------------------------------------
	// Bus sizing
	// ----------------------------------------

	// Masters sharing the write bus
	localparam int BlockNum       = 3;
	localparam int BlockIdWidth   = 4;
	// Data width follows the external RAM
	localparam int DqWidth        = 16;
	localparam int RamAdrsWidth   = 25;
	// Only the low address bits exist in the slave model
	localparam int RamDepthBits   = 8;
	localparam int BurstLen       = 4;

	// ----------------------------------------
	// Timing constants
	// ----------------------------------------

	// Idle cycles before the arbiter moves on
	localparam int IdleSlotCycles = 6;
	// Counter values where ready is offered
	localparam int GrantWindow    = 3;
	localparam int ReadLatency    = 2;
	// One ready drop per period
	localparam int RefreshPeriod  = 32;

	// Derived widths
	localparam int SelWidth        = $clog2(BlockNum);
	localparam int IdleCntWidth    = $clog2(IdleSlotCycles + 1);
	localparam int BeatCntWidth    = $clog2(BurstLen + 1);
	localparam int BeatIdxWidth    = $clog2(BurstLen);
	localparam int RefreshCntWidth = $clog2(RefreshPeriod);
	localparam int RamDepth        = 2 ** RamDepthBits;

	// ----------------------------------------
	// Bus types
	// ----------------------------------------

	typedef logic [BlockIdWidth-1:0] blockIdT;
	typedef logic [RamAdrsWidth-1:0] ramAdrsT;
	typedef logic [DqWidth-1:0]      dqT;

	// Address word, enable on bit 31
	typedef struct packed {
		logic    enable;
		logic    readCmd;
		logic    spare;
		blockIdT blockId;
		ramAdrsT ramAdrs;
	} ufiAdrsT;

	// One bus beat
	typedef struct packed {
		ufiAdrsT adrs;
		dqT      dq;
	} ufiWordT;

	typedef enum logic {opWrite, opRead} ufiOpE;

	// Burst command, wd[0] goes out first
	typedef struct packed {
		ufiOpE                  op;
		ramAdrsT                ramAdrs;
		logic [BurstLen-1:0][DqWidth-1:0] wd;
	} ufiCmdT;

	// Returned read word
	typedef struct packed {
		ramAdrsT ramAdrs;
		dqT      data;
	} ufiRdT;

endpackage

`default_nettype wire

// ==== ufiBusArbiter.sv ====
// UFI bus rotating arbiter
`timescale 1ns/1ps
`default_nettype none

module ufiBusArbiter (
	input  wire                         iCLK,
	input  wire                         iRST,
	// Master write side
	input  wire ufiPkg::ufiWordT        mWord [ufiPkg::BlockNum],
	output logic [ufiPkg::BlockNum-1:0] mRdy,
	// Slave write side
	output ufiPkg::ufiWordT             sWord,
	input  wire                         sRdy,
	// Read return path
	input  wire ufiPkg::ufiWordT        sRdWord,
	output ufiPkg::ufiWordT             mRdWord
);

	// Current owner and its idle time
	logic [ufiPkg::SelWidth-1:0]     sel;
	logic [ufiPkg::IdleCntWidth-1:0] idleCnt;

	// Selected master view
	ufiPkg::ufiWordT selWord;
	logic            selEn;
	logic            selXfer;
	logic            selAdvance;

	// Registered write path toward the slave
	ufiPkg::ufiWordT sWordReg;
	logic            sEnReg;

	// ----------------------------------------
	// Selection
	// ----------------------------------------

	assign selWord = mWord[sel];
	assign selEn   = selWord.adrs.enable;
	// Beat moves when owner has a word and sees ready
	assign selXfer = selEn & mRdy[sel];
	// Owner stayed quiet for the whole slot
	assign selAdvance = ~selEn & (int'(idleCnt) == ufiPkg::IdleSlotCycles);

	// Rotating select, master 0 after reset
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			sel <= '0;
		else if (selAdvance)
		begin
			// Wrap after the last master
			if (int'(sel) == ufiPkg::BlockNum - 1)
				sel <= '0;
			else
				sel <= sel + 1'b1;
		end
	end

	// Idle counter, held at zero while the owner drives
	always_ff @(posedge iCLK)
	begin
		if (iRST || selEn || selAdvance)
			idleCnt <= '0;
		else
			idleCnt <= idleCnt + 1'b1;
	end

	// ----------------------------------------
	// Ready generation
	// ----------------------------------------

	// Straight from state so a beat moves in the same cycle
	always_comb
	begin
		for (int i = 0; i < ufiPkg::BlockNum; i++)
		begin
			mRdy[i] = sRdy && (int'(sel) == i)
				&& (int'(idleCnt) < ufiPkg::GrantWindow);
		end
	end

	// ----------------------------------------
	// Write path register
	// ----------------------------------------

	always_ff @(posedge iCLK)
	begin
		sWordReg <= selWord;
	end

	// Enable only for beats that really transferred
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			sEnReg <= 1'b0;
		else
			sEnReg <= selXfer;
	end

	always_comb
	begin
		sWord             = sWordReg;
		sWord.adrs.enable = sEnReg;
	end

	// Read data goes to everyone, masters filter by ID
	assign mRdWord = sRdWord;

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	// Never two owners
	assert property (@(posedge iCLK) disable iff (iRST) $onehot0(mRdy))
		else $error("ufiBusArbiter: more than one ready bit high");

	// Select stays within the connected masters
	assert property (@(posedge iCLK) disable iff (iRST) int'(sel) < ufiPkg::BlockNum)
		else $error("ufiBusArbiter: select out of range");

endmodule

`default_nettype wire

// ==== ufiMaster.sv ====
// UFI bus burst master
`timescale 1ns/1ps
`default_nettype none

module ufiMaster #(
	parameter ufiPkg::blockIdT BlockId = 4'd1
) (
	input  wire                  iCLK,
	input  wire                  iRST,
	// Burst command from the client
	input  wire ufiPkg::ufiCmdT  cmd,
	input  wire                  cmdStrobe,
	output logic                 busy,
	// Bus write side
	output ufiPkg::ufiWordT      word,
	input  wire                  rdy,
	// Shared read return
	input  wire ufiPkg::ufiWordT rdWord,
	output ufiPkg::ufiRdT        rdResult,
	output logic                 rdStrobe
);

	typedef enum logic [1:0] {idle, issue, waitRead} mstStateE;

	mstStateE                        state;
	ufiPkg::ufiCmdT                  cmdReg;
	// Beats sent and read words collected
	logic [ufiPkg::BeatCntWidth-1:0] beatCnt;
	logic [ufiPkg::BeatCntWidth-1:0] rdCnt;
	logic                            xfer;
	logic                            lastBeat;
	logic                            rdMatch;
	logic                            lastRead;

	assign busy     = (state != idle);
	assign xfer     = word.adrs.enable & rdy;
	assign lastBeat = (int'(beatCnt) == ufiPkg::BurstLen - 1);
	assign lastRead = (int'(rdCnt) == ufiPkg::BurstLen - 1);
	// Own read returns only
	assign rdMatch  = rdWord.adrs.enable & rdWord.adrs.readCmd
		& (rdWord.adrs.blockId == BlockId) & busy;

	// Beat on the bus
	always_comb
	begin
		word              = '0;
		word.adrs.enable  = (state == issue);
		word.adrs.readCmd = (cmdReg.op == ufiPkg::opRead);
		word.adrs.blockId = BlockId;
		// Address steps once per beat
		word.adrs.ramAdrs = cmdReg.ramAdrs + ufiPkg::ramAdrsT'(beatCnt);
		word.dq           = cmdReg.wd[beatCnt[ufiPkg::BeatIdxWidth-1:0]];
	end

	// Command capture, strobes while busy drop here
	always_ff @(posedge iCLK)
	begin
		if ((state == idle) && cmdStrobe)
			cmdReg <= cmd;
	end

	// ----------------------------------------
	// Burst FSM
	// ----------------------------------------

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state   <= idle;
			beatCnt <= '0;
			rdCnt   <= '0;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (cmdStrobe)
					begin
						state   <= issue;
						beatCnt <= '0;
						rdCnt   <= '0;
					end
				end
				issue:
				begin
					if (xfer)
					begin
						beatCnt <= beatCnt + 1'b1;
						// Writes end on the last beat, reads wait for data
						if (lastBeat)
							state <= (cmdReg.op == ufiPkg::opRead) ? waitRead : idle;
					end
					// Early returns can overlap issuing
					if (rdMatch)
						rdCnt <= rdCnt + 1'b1;
				end
				waitRead:
				begin
					if (rdMatch)
					begin
						rdCnt <= rdCnt + 1'b1;
						if (lastRead)
							state <= idle;
					end
				end
				default:
					state <= idle;
			endcase
		end
	end

	// Read result, one cycle per word
	always_ff @(posedge iCLK)
	begin
		rdResult.ramAdrs <= rdWord.adrs.ramAdrs;
		rdResult.data    <= rdWord.dq;
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			rdStrobe <= 1'b0;
		else
			rdStrobe <= rdMatch;
	end

	// Burst length is never overrun
	assert property (@(posedge iCLK) disable iff (iRST) int'(beatCnt) <= ufiPkg::BurstLen)
		else $error("ufiMaster: beat counter past burst length");

	// No read word beyond the burst comes back
	assert property (@(posedge iCLK) disable iff (iRST)
		rdMatch |-> int'(rdCnt) < ufiPkg::BurstLen)
		else $error("ufiMaster: extra read word for block %0d", BlockId);

endmodule

`default_nettype wire

// ==== ufiRamSlave.sv ====
// UFI bus RAM slave model
`timescale 1ns/1ps
`default_nettype none

module ufiRamSlave (
	input  wire                  iCLK,
	input  wire                  iRST,
	// Registered beat from the arbiter
	input  wire ufiPkg::ufiWordT word,
	output logic                 rdy,
	// Read return
	output ufiPkg::ufiWordT      rdWord
);

	localparam int LastStage = ufiPkg::ReadLatency - 1;

	// Storage
	ufiPkg::dqT                         mem [ufiPkg::RamDepth];
	logic [ufiPkg::RamDepthBits-1:0]    memAdrs;
	logic                               wrEn;
	logic                               rdEn;

	// Read pipeline
	ufiPkg::ufiAdrsT                    adrsPipe [ufiPkg::ReadLatency];
	ufiPkg::dqT                         dataPipe [ufiPkg::ReadLatency];
	logic [ufiPkg::ReadLatency-1:0]     vldPipe;

	// Refresh timer
	logic [ufiPkg::RefreshCntWidth-1:0] refCnt;

	// Upper address bits are not decoded
	assign memAdrs = word.adrs.ramAdrs[ufiPkg::RamDepthBits-1:0];
	// Every enabled word is taken, ready or not
	assign wrEn    = word.adrs.enable & ~word.adrs.readCmd;
	assign rdEn    = word.adrs.enable & word.adrs.readCmd;

	// ----------------------------------------
	// Memory and read pipeline
	// ----------------------------------------

	always_ff @(posedge iCLK)
	begin
		if (wrEn)
			mem[memAdrs] <= word.dq;
	end

	// Stage 0 samples the array, later stages only delay
	always_ff @(posedge iCLK)
	begin
		adrsPipe[0] <= word.adrs;
		dataPipe[0] <= mem[memAdrs];
		for (int i = 1; i < ufiPkg::ReadLatency; i++)
		begin
			adrsPipe[i] <= adrsPipe[i-1];
			dataPipe[i] <= dataPipe[i-1];
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			vldPipe <= '0;
		else
		begin
			vldPipe[0] <= rdEn;
			for (int i = 1; i < ufiPkg::ReadLatency; i++)
				vldPipe[i] <= vldPipe[i-1];
		end
	end

	// Request address comes back with the data
	always_comb
	begin
		rdWord             = '0;
		rdWord.adrs        = adrsPipe[LastStage];
		rdWord.adrs.enable = vldPipe[LastStage];
		rdWord.dq          = dataPipe[LastStage];
	end

	// ----------------------------------------
	// Refresh
	// ----------------------------------------

	always_ff @(posedge iCLK)
	begin
		if (iRST || (int'(refCnt) == ufiPkg::RefreshPeriod - 1))
			refCnt <= '0;
		else
			refCnt <= refCnt + 1'b1;
	end

	// Low for the last cycle of each period
	assign rdy = (int'(refCnt) != ufiPkg::RefreshPeriod - 1);

endmodule

`default_nettype wire

// ==== ufiSubsystem.sv ====
// UFI shared memory subsystem
`timescale 1ns/1ps
`default_nettype none

module ufiSubsystem (
	input  wire                        iCLK,
	input  wire                        iRST,
	// Client commands, one per master
	input  wire ufiPkg::ufiCmdT        cmd [ufiPkg::BlockNum],
	input  wire [ufiPkg::BlockNum-1:0] cmdStrobe,
	output wire [ufiPkg::BlockNum-1:0] busy,
	// Read results per master
	output wire ufiPkg::ufiRdT         rdResult [ufiPkg::BlockNum],
	output wire [ufiPkg::BlockNum-1:0] rdStrobe
);

	// Master to arbiter
	wire ufiPkg::ufiWordT        mWord [ufiPkg::BlockNum];
	wire [ufiPkg::BlockNum-1:0]  mRdy;
	// Arbiter to slave and back
	wire ufiPkg::ufiWordT        sWord;
	wire                         sRdy;
	wire ufiPkg::ufiWordT        sRdWord;
	// Shared read return
	wire ufiPkg::ufiWordT        mRdWord;

	// ----------------------------------------
	// Masters, block IDs start at 1
	// ----------------------------------------

	for (genvar i = 0; i < ufiPkg::BlockNum; i++)
	begin : genMaster
		ufiMaster #(
			.BlockId   (ufiPkg::blockIdT'(i + 1))
		) master_i (
			.iCLK      (iCLK),
			.iRST      (iRST),
			.cmd       (cmd[i]),
			.cmdStrobe (cmdStrobe[i]),
			.busy      (busy[i]),
			.word      (mWord[i]),
			.rdy       (mRdy[i]),
			.rdWord    (mRdWord),
			.rdResult  (rdResult[i]),
			.rdStrobe  (rdStrobe[i])
		);
	end

	// Write bus owner select
	ufiBusArbiter arbiter_i (
		.iCLK    (iCLK),
		.iRST    (iRST),
		.mWord   (mWord),
		.mRdy    (mRdy),
		.sWord   (sWord),
		.sRdy    (sRdy),
		.sRdWord (sRdWord),
		.mRdWord (mRdWord)
	);

	// On-chip RAM standing in for external memory
	ufiRamSlave slave_i (
		.iCLK   (iCLK),
		.iRST   (iRST),
		.word   (sWord),
		.rdy    (sRdy),
		.rdWord (sRdWord)
	);

endmodule

`default_nettype wire

// ==== ufiSubsystemTb.sv ====
// UFI subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module ufiSubsystemTb;

	localparam int ClkPeriod    = 20;
	localparam int ResetCycles  = 16;
	// Row layout: mode master op adrs wd0..wd3
	localparam int WordsPerPat  = 8;
	localparam int MaxPat       = 64;
	// Rotation through all masters, refresh drop, read latency and idle gap
	localparam int CyclesPerPat = 100;

	typedef logic [ufiPkg::BlockNum-1:0] blockVecT;

	// DUT side
	logic          iCLK;
	logic          iRST;
	ufiPkg::ufiCmdT cmd [ufiPkg::BlockNum];
	blockVecT      cmdStrobe;
	blockVecT      busy;
	ufiPkg::ufiRdT rdResult [ufiPkg::BlockNum];
	blockVecT      rdStrobe;

	// Pattern storage
	logic [31:0]   patMem [MaxPat * WordsPerPat];
	int            patCount;
	logic          loaded;
	logic [31:0]   seed;

	// Expected read words per master, monitor walks them by index
	ufiPkg::ufiRdT expRd [ufiPkg::BlockNum][$];
	int            rdIdx [ufiPkg::BlockNum] = '{default: 0};

	// Error counters
	int            vecErrs;
	int            mainFails;
	int            rdErrs = 0;
	int            monFails = 0;

	ufiSubsystem dut_i (
		.iCLK      (iCLK),
		.iRST      (iRST),
		.cmd       (cmd),
		.cmdStrobe (cmdStrobe),
		.busy      (busy),
		.rdResult  (rdResult),
		.rdStrobe  (rdStrobe)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #(ClkPeriod / 2) iCLK = ~iCLK;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] patWord(input int p, input int f);
		return patMem[p * WordsPerPat + f];
	endfunction

	function automatic int masterOf(input int p);
		return int'(patWord(p, 1));
	endfunction

	task automatic checkRead(input int m, input ufiPkg::ufiRdT got, input ufiPkg::ufiRdT exp);
		if (got !== exp)
		begin
			rdErrs++;
			$display("mismatch rdResult[%0d]: got adrs %h data %h, expected adrs %h data %h",
				m, got.ramAdrs, got.data, exp.ramAdrs, exp.data);
		end
	endtask

	task automatic verifyVector(input string name, input blockVecT got, input blockVecT exp);
		if (got !== exp)
		begin
			vecErrs++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Puts a pattern row on its master's command port
	task automatic loadCmd(input int p, input logic track);
		int             m;
		ufiPkg::ufiCmdT c;
		ufiPkg::ufiRdT  r;
		m         = masterOf(p);
		c.op      = (patWord(p, 2) == 32'd1) ? ufiPkg::opRead : ufiPkg::opWrite;
		c.ramAdrs = ufiPkg::ramAdrsT'(patWord(p, 3));
		for (int k = 0; k < ufiPkg::BurstLen; k++)
		begin
			c.wd[k] = ufiPkg::dqT'(patWord(p, 4 + k));
			// Read rows carry the expected data, address steps per word
			if (track && (c.op == ufiPkg::opRead))
			begin
				r.ramAdrs = c.ramAdrs + ufiPkg::ramAdrsT'(k);
				r.data    = c.wd[k];
				expRd[m].push_back(r);
			end
		end
		cmd[m] = c;
	endtask

	task automatic waitIdle(input blockVecT mask);
		while ((busy & mask) != '0)
			@(negedge iCLK);
		// Last read word strobes as busy falls
		@(negedge iCLK);
	endtask

	// ----------------------------------------
	// Read return monitor
	// ----------------------------------------

	always @(negedge iCLK)
	begin
		if (!iRST)
		begin
			for (int m = 0; m < ufiPkg::BlockNum; m++)
			begin
				if (rdStrobe[m])
				begin
					if (rdIdx[m] < expRd[m].size())
						checkRead(m, rdResult[m], expRd[m][rdIdx[m]]);
					else
					begin
						monFails++;
						$display("unexpected read word on master %0d, adrs %h data %h",
							m, rdResult[m].ramAdrs, rdResult[m].data);
					end
					rdIdx[m]++;
				end
			end
		end
	end

	// Watchdog
	initial
	begin
		wait (loaded);
		repeat (ResetCycles + patCount * CyclesPerPat) @(posedge iCLK);
		$display("timeout: patterns did not finish within %0d cycles",
			ResetCycles + patCount * CyclesPerPat);
		$display("Test failed");
		$finish;
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------

	initial
	begin
		int       idx;
		int       total;
		blockVecT mask;
		iRST      = 1'b1;
		cmdStrobe = '0;
		for (int m = 0; m < ufiPkg::BlockNum; m++)
			cmd[m] = '0;
		vecErrs   = 0;
		mainFails = 0;
		loaded    = 1'b0;
		seed      = 32'h48c870de;
		patCount  = 0;

		$readmemh("ufiPatterns.txt", patMem);
		// Mode f closes the list
		while ((patCount < MaxPat) && (patMem[patCount * WordsPerPat] != 32'hf))
			patCount++;
		loaded = 1'b1;

		repeat (ResetCycles) @(negedge iCLK);
		iRST = 1'b0;
		@(negedge iCLK);
		verifyVector("busy", busy, '0);
		verifyVector("rdStrobe", rdStrobe, '0);

		idx = 0;
		while (idx < patCount)
		begin
			seed = lcgNext(seed);
			repeat (int'(seed[18:16])) @(negedge iCLK);
			mask = '0;
			if (patWord(idx, 0) == 32'd1)
			begin
				// Same-cycle group, a repeated master starts the next group
				while ((idx < patCount) && (patWord(idx, 0) == 32'd1)
					&& !mask[masterOf(idx)])
				begin
					loadCmd(idx, 1'b1);
					mask[masterOf(idx)] = 1'b1;
					idx++;
				end
				cmdStrobe = mask;
				@(negedge iCLK);
				cmdStrobe = '0;
			end
			else
			begin
				loadCmd(idx, 1'b1);
				mask[masterOf(idx)] = 1'b1;
				cmdStrobe = mask;
				@(negedge iCLK);
				cmdStrobe = '0;
				idx++;
				// Second strobe lands while the burst is running
				if ((idx < patCount) && (patWord(idx, 0) == 32'd2))
				begin
					if (!busy[masterOf(idx)])
					begin
						mainFails++;
						$display("master %0d was not busy when the extra strobe was sent",
							masterOf(idx));
					end
					loadCmd(idx, 1'b0);
					cmdStrobe[masterOf(idx)] = 1'b1;
					@(negedge iCLK);
					cmdStrobe = '0;
					idx++;
				end
			end
			waitIdle(mask);
		end

		// Nothing lost, nothing extra
		for (int m = 0; m < ufiPkg::BlockNum; m++)
		begin
			if (rdIdx[m] != expRd[m].size())
			begin
				mainFails++;
				$display("master %0d returned %0d read words, expected %0d",
					m, rdIdx[m], expRd[m].size());
			end
		end

		total = vecErrs + rdErrs + mainFails + monFails;
		$display("errors: %0d read mismatches, %0d vector mismatches, %0d other failures",
			rdErrs, vecErrs, mainFails + monFails);
		if (total == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ufiPatterns.txt ====
// Columns: mode master op adrs wd0 wd1 wd2 wd3, all hex; read rows hold expected data
// Mode 0 solo, 1 same-cycle group, 2 strobe to the still busy master, f end of list
// Single master write then read back
0 0 0 00000010 a001 a002 a003 a004
0 0 1 00000010 a001 a002 a003 a004
0 1 0 00000020 b011 b012 b013 b014
0 1 1 00000020 b011 b012 b013 b014
0 2 0 00000030 c021 c022 c023 c024
0 2 1 00000030 c021 c022 c023 c024
// Same-cycle writes to disjoint regions
1 0 0 00000040 d100 d101 d102 d103
1 1 0 00000050 d200 d201 d202 d203
1 2 0 00000060 d300 d301 d302 d303
// Readback through other masters
0 0 1 00000050 d200 d201 d202 d203
0 1 1 00000060 d300 d301 d302 d303
0 2 1 00000040 d100 d101 d102 d103
1 0 1 00000060 d300 d301 d302 d303
1 1 1 00000040 d100 d101 d102 d103
1 2 1 00000050 d200 d201 d202 d203
// Strobes while busy are dropped
0 1 0 00000070 e001 e002 e003 e004
2 1 0 00000070 dead dead dead dead
0 0 1 00000070 e001 e002 e003 e004
0 2 1 00000010 a001 a002 a003 a004
2 2 1 00000020 b011 b012 b013 b014
// Longer mixed run across refresh drops
0 2 0 00000080 f0f0 0f0f 1234 5678
1 0 0 00000090 9001 9002 9003 9004
1 1 0 000000a0 a0a1 a0a2 a0a3 a0a4
1 2 1 00000080 f0f0 0f0f 1234 5678
0 1 1 00000090 9001 9002 9003 9004
0 0 1 000000a0 a0a1 a0a2 a0a3 a0a4
0 1 0 000000fc 7777 8888 9999 aaaa
0 2 1 000000fc 7777 8888 9999 aaaa
1 0 1 00000030 c021 c022 c023 c024
1 1 1 000000fc 7777 8888 9999 aaaa
1 2 1 00000070 e001 e002 e003 e004
0 0 1 00000020 b011 b012 b013 b014
f 0 0 00000000 0000 0000 0000 0000

// ==== Makefile ====
SIM      = verilator
TOP      = ufiSubsystemTb
FILELIST = ufiSubsystem.f
FLAGS    = --binary --timing --assert -j 0
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(OBJDIR)

// ==== ufiSubsystem.f ====
ufiPkg.sv
ufiBusArbiter.sv
ufiMaster.sv
ufiRamSlave.sv
ufiSubsystem.sv
ufiSubsystemTb.sv
